//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // instruction cache geometry, one word per line
  localparam int icache_lines = 16;
  localparam int icache_index_width = 4;
  localparam int icache_tag_width = addr_width - icache_index_width - 2;

  // core-local timer region
  localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
  // upper half of the address selects the region
  localparam logic [addr_width-1:0] clint_mask = 32'hffff_0000;

  // word offsets inside the region
  localparam logic [15:0] clint_mtime_lo = 16'hbff8;
  localparam logic [15:0] clint_mtime_hi = 16'hbffc;

  // axi response codes
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

//--- design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            timer_hi,
  output logic [mem_pkg::data_width-1:0] timer_rdata
);

  localparam int count_width = 2 * mem_pkg::data_width;

  logic [count_width-1:0] mtime;

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + count_width'(1);
    end
  end

  // word select for the read port
  always_comb begin
    if (timer_hi) begin
      timer_rdata = mtime[count_width-1:mem_pkg::data_width];
    end else begin
      timer_rdata = mtime[mem_pkg::data_width-1:0];
    end
  end

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic                            clock,
  input  logic                            reset,
  // fetch side
  input  logic                            fetch_valid,
  input  logic [mem_pkg::addr_width-1:0] fetch_addr,
  output logic                            fetch_ready,
  output logic                            fetch_resp_valid,
  output logic [mem_pkg::data_width-1:0] fetch_resp_data,
  // refill side
  output logic                            refill_valid,
  output logic [mem_pkg::addr_width-1:0] refill_addr,
  input  logic                            refill_ready,
  input  logic                            refill_resp_valid,
  input  logic [mem_pkg::data_width-1:0] refill_resp_data
);

  localparam int idx_w = mem_pkg::icache_index_width;
  localparam int tag_w = mem_pkg::icache_tag_width;

  typedef enum logic [1:0] {
    st_idle,
    st_refill,
    st_wait
  } state_t;

  state_t state;

  logic [mem_pkg::icache_lines-1:0] line_valid;
  logic [tag_w-1:0]                 tag_mem [mem_pkg::icache_lines];
  logic [mem_pkg::data_width-1:0]   data_mem [mem_pkg::icache_lines];

  logic [idx_w-1:0]               fetch_idx;
  logic [tag_w-1:0]               fetch_tag;
  logic [mem_pkg::addr_width-1:0] miss_addr;
  logic [idx_w-1:0]               miss_idx;
  logic [tag_w-1:0]               miss_tag;

  logic                           accept;
  logic                           hit;
  logic                           refill_valid_q;
  logic                           resp_valid_q;
  logic [mem_pkg::data_width-1:0] resp_data_q;

  assign fetch_idx = fetch_addr[idx_w+1:2];
  assign fetch_tag = fetch_addr[mem_pkg::addr_width-1 -: tag_w];
  assign miss_idx  = miss_addr[idx_w+1:2];
  assign miss_tag  = miss_addr[mem_pkg::addr_width-1 -: tag_w];

  // lookup happens in the accepting cycle
  assign hit    = line_valid[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
  assign accept = fetch_valid && fetch_ready;

  assign fetch_ready      = (state == st_idle);
  assign fetch_resp_valid = resp_valid_q;
  assign fetch_resp_data  = resp_data_q;

  // refill is always word aligned
  assign refill_valid = refill_valid_q;
  assign refill_addr  = {miss_addr[mem_pkg::addr_width-1:2], 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= st_idle;
      line_valid     <= '0;
      refill_valid_q <= 1'b0;
      resp_valid_q   <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      case (state)
        st_idle: begin
          if (accept && hit) begin
            resp_valid_q <= 1'b1;
          end else if (accept) begin
            refill_valid_q <= 1'b1;
            state          <= st_refill;
          end
        end
        st_refill: begin
          if (refill_ready) begin
            refill_valid_q <= 1'b0;
            state          <= st_wait;
          end
        end
        st_wait: begin
          if (refill_resp_valid) begin
            line_valid[miss_idx] <= 1'b1;
            resp_valid_q         <= 1'b1;
            state                <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // arrays and response word
  always_ff @(posedge clock) begin
    if (accept) begin
      miss_addr   <= fetch_addr;
      resp_data_q <= data_mem[fetch_idx];
    end
    if (state == st_wait && refill_resp_valid) begin
      tag_mem[miss_idx]  <= miss_tag;
      data_mem[miss_idx] <= refill_resp_data;
      // miss data goes straight back to the fetch side
      resp_data_q        <= refill_resp_data;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                            clock,
  input  logic                            reset,
  // load/store port
  input  logic                            lsu_valid,
  input  logic                            lsu_write,
  input  logic [mem_pkg::addr_width-1:0] lsu_addr,
  input  logic [mem_pkg::data_width-1:0] lsu_wdata,
  input  logic [mem_pkg::strb_width-1:0] lsu_strb,
  output logic                            lsu_ready,
  output logic                            lsu_resp_valid,
  output logic [mem_pkg::data_width-1:0] lsu_resp_data,
  // cache refill port
  input  logic                            refill_valid,
  input  logic [mem_pkg::addr_width-1:0] refill_addr,
  output logic                            refill_ready,
  output logic                            refill_resp_valid,
  output logic [mem_pkg::data_width-1:0] refill_resp_data,
  // timer read
  output logic                            timer_hi,
  input  logic [mem_pkg::data_width-1:0] timer_rdata,
  // axi master
  output logic                            arvalid,
  output logic [mem_pkg::addr_width-1:0] araddr,
  input  logic                            arready,
  input  logic                            rvalid,
  input  logic [mem_pkg::data_width-1:0] rdata,
  input  logic [1:0]                      rresp,
  input  logic                            rlast,
  output logic                            rready,
  output logic                            awvalid,
  output logic [mem_pkg::addr_width-1:0] awaddr,
  input  logic                            awready,
  output logic                            wvalid,
  output logic [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::strb_width-1:0] wstrb,
  output logic                            wlast,
  input  logic                            wready,
  input  logic                            bvalid,
  input  logic [1:0]                      bresp,
  output logic                            bready
);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_data,
    st_wr_addr,
    st_wr_resp,
    st_timer
  } state_t;

  state_t state;

  logic                           lsu_in_timer;
  logic                           take_lsu;
  logic                           take_refill;
  logic                           r_done;
  logic                           b_done;
  logic                           aw_left;
  logic                           w_left;
  logic [mem_pkg::data_width-1:0] rd_word;
  logic [mem_pkg::data_width-1:0] timer_word;
  logic [15:0]                    lat_offset;

  logic                           lat_lsu;
  logic                           lat_write;
  logic [mem_pkg::addr_width-1:0] lat_addr;
  logic [mem_pkg::data_width-1:0] lat_wdata;
  logic [mem_pkg::strb_width-1:0] lat_strb;
  logic                           arvalid_q;
  logic                           awvalid_q;
  logic                           wvalid_q;
  logic                           lsu_rsp_q;
  logic                           refill_rsp_q;
  logic [mem_pkg::data_width-1:0] rsp_data_q;

  assign lsu_in_timer = (lsu_addr & mem_pkg::clint_mask) ==
                        (mem_pkg::clint_base & mem_pkg::clint_mask);

  // load/store wins a tie
  assign lsu_ready    = (state == st_idle);
  assign refill_ready = (state == st_idle) && !lsu_valid;
  assign take_lsu     = lsu_valid && lsu_ready;
  assign take_refill  = refill_valid && refill_ready;

  assign arvalid = arvalid_q;
  assign araddr  = lat_addr;
  assign rready  = (state == st_rd_data);
  assign awvalid = awvalid_q;
  assign awaddr  = lat_addr;
  assign wvalid  = wvalid_q;
  assign wdata   = lat_wdata;
  assign wstrb   = lat_strb;
  assign wlast   = wvalid_q;
  assign bready  = (state == st_wr_resp);

  assign r_done  = rvalid && rready;
  assign b_done  = bvalid && bready;
  assign aw_left = awvalid_q && !awready;
  assign w_left  = wvalid_q && !wready;

  // error or truncated beat returns zero
  assign rd_word = (rresp == mem_pkg::resp_okay && rlast) ? rdata : '0;

  // timer access served from the latched offset
  assign lat_offset = lat_addr[15:0];
  assign timer_hi   = (lat_offset == mem_pkg::clint_mtime_hi);
  assign timer_word = (!lat_write && (timer_hi || lat_offset == mem_pkg::clint_mtime_lo)) ?
                      timer_rdata : '0;

  assign lsu_resp_valid    = lsu_rsp_q || (state == st_timer);
  assign lsu_resp_data     = (state == st_timer) ? timer_word : rsp_data_q;
  assign refill_resp_valid = refill_rsp_q;
  assign refill_resp_data  = rsp_data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= st_idle;
      lat_lsu      <= 1'b0;
      arvalid_q    <= 1'b0;
      awvalid_q    <= 1'b0;
      wvalid_q     <= 1'b0;
      lsu_rsp_q    <= 1'b0;
      refill_rsp_q <= 1'b0;
    end else begin
      lsu_rsp_q    <= 1'b0;
      refill_rsp_q <= 1'b0;
      case (state)
        st_idle: begin
          if (take_lsu) begin
            lat_lsu <= 1'b1;
            if (lsu_in_timer) begin
              state <= st_timer;
            end else if (lsu_write) begin
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
              state     <= st_wr_addr;
            end else begin
              arvalid_q <= 1'b1;
              state     <= st_rd_addr;
            end
          end else if (take_refill) begin
            lat_lsu   <= 1'b0;
            arvalid_q <= 1'b1;
            state     <= st_rd_addr;
          end
        end
        st_rd_addr: begin
          if (arvalid_q && arready) begin
            arvalid_q <= 1'b0;
            state     <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (r_done) begin
            lsu_rsp_q    <= lat_lsu;
            refill_rsp_q <= !lat_lsu;
            state        <= st_idle;
          end
        end
        st_wr_addr: begin
          // aw and w retire independently
          if (awready) awvalid_q <= 1'b0;
          if (wready) wvalid_q <= 1'b0;
          if (!aw_left && !w_left) state <= st_wr_resp;
        end
        st_wr_resp: begin
          if (b_done) begin
            lsu_rsp_q <= 1'b1;
            state     <= st_idle;
          end
        end
        st_timer: state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // request payload and returned word
  always_ff @(posedge clock) begin
    if (take_lsu) begin
      lat_addr  <= lsu_addr;
      lat_write <= lsu_write;
      lat_wdata <= lsu_wdata;
      lat_strb  <= lsu_strb;
    end else if (take_refill) begin
      lat_addr  <= refill_addr;
      lat_write <= 1'b0;
    end
    if (r_done) begin
      rsp_data_q <= rd_word;
    end else if (b_done) begin
      // zero on okay
      rsp_data_q <= {{(mem_pkg::data_width-2){1'b0}}, bresp};
    end
  end

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  logic                            clock,
  input  logic                            reset,
  // instruction fetch
  input  logic                            fetch_valid,
  input  logic [mem_pkg::addr_width-1:0] fetch_addr,
  output logic                            fetch_ready,
  output logic                            fetch_resp_valid,
  output logic [mem_pkg::data_width-1:0] fetch_resp_data,
  // load/store
  input  logic                            lsu_valid,
  input  logic                            lsu_write,
  input  logic [mem_pkg::addr_width-1:0] lsu_addr,
  input  logic [mem_pkg::data_width-1:0] lsu_wdata,
  input  logic [mem_pkg::strb_width-1:0] lsu_strb,
  output logic                            lsu_ready,
  output logic                            lsu_resp_valid,
  output logic [mem_pkg::data_width-1:0] lsu_resp_data,
  // axi master
  output logic                            arvalid,
  output logic [mem_pkg::addr_width-1:0] araddr,
  input  logic                            arready,
  input  logic                            rvalid,
  input  logic [mem_pkg::data_width-1:0] rdata,
  input  logic [1:0]                      rresp,
  input  logic                            rlast,
  output logic                            rready,
  output logic                            awvalid,
  output logic [mem_pkg::addr_width-1:0] awaddr,
  input  logic                            awready,
  output logic                            wvalid,
  output logic [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::strb_width-1:0] wstrb,
  output logic                            wlast,
  input  logic                            wready,
  input  logic                            bvalid,
  input  logic [1:0]                      bresp,
  output logic                            bready
);

  logic                           refill_valid;
  logic [mem_pkg::addr_width-1:0] refill_addr;
  logic                           refill_ready;
  logic                           refill_resp_valid;
  logic [mem_pkg::data_width-1:0] refill_resp_data;
  logic                           timer_hi;
  logic [mem_pkg::data_width-1:0] timer_rdata;

  icache i_icache (
    .clock             (clock),
    .reset             (reset),
    .fetch_valid       (fetch_valid),
    .fetch_addr        (fetch_addr),
    .fetch_ready       (fetch_ready),
    .fetch_resp_valid  (fetch_resp_valid),
    .fetch_resp_data   (fetch_resp_data),
    .refill_valid      (refill_valid),
    .refill_addr       (refill_addr),
    .refill_ready      (refill_ready),
    .refill_resp_valid (refill_resp_valid),
    .refill_resp_data  (refill_resp_data)
  );

  mem_arbiter i_arbiter (
    .clock             (clock),
    .reset             (reset),
    .lsu_valid         (lsu_valid),
    .lsu_write         (lsu_write),
    .lsu_addr          (lsu_addr),
    .lsu_wdata         (lsu_wdata),
    .lsu_strb          (lsu_strb),
    .lsu_ready         (lsu_ready),
    .lsu_resp_valid    (lsu_resp_valid),
    .lsu_resp_data     (lsu_resp_data),
    .refill_valid      (refill_valid),
    .refill_addr       (refill_addr),
    .refill_ready      (refill_ready),
    .refill_resp_valid (refill_resp_valid),
    .refill_resp_data  (refill_resp_data),
    .timer_hi          (timer_hi),
    .timer_rdata       (timer_rdata),
    .arvalid           (arvalid),
    .araddr            (araddr),
    .arready           (arready),
    .rvalid            (rvalid),
    .rdata             (rdata),
    .rresp             (rresp),
    .rlast             (rlast),
    .rready            (rready),
    .awvalid           (awvalid),
    .awaddr            (awaddr),
    .awready           (awready),
    .wvalid            (wvalid),
    .wdata             (wdata),
    .wstrb             (wstrb),
    .wlast             (wlast),
    .wready            (wready),
    .bvalid            (bvalid),
    .bresp             (bresp),
    .bready            (bready)
  );

  clint_timer i_clint (
    .clock       (clock),
    .reset       (reset),
    .timer_hi    (timer_hi),
    .timer_rdata (timer_rdata)
  );

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            arvalid,
  input  logic [mem_pkg::addr_width-1:0] araddr,
  output logic                            arready,
  output logic                            rvalid,
  output logic [mem_pkg::data_width-1:0] rdata,
  output logic [1:0]                      rresp,
  output logic                            rlast,
  input  logic                            rready,
  input  logic                            awvalid,
  input  logic [mem_pkg::addr_width-1:0] awaddr,
  output logic                            awready,
  input  logic                            wvalid,
  input  logic [mem_pkg::data_width-1:0] wdata,
  input  logic [mem_pkg::strb_width-1:0] wstrb,
  input  logic                            wlast,
  output logic                            wready,
  output logic                            bvalid,
  output logic [1:0]                      bresp,
  input  logic                            bready,
  output logic [31:0]                     read_count,
  output logic [31:0]                     write_count
);

  integer seed = 32'hd740;

  // only written words live here
  logic [mem_pkg::data_width-1:0] mem [logic [mem_pkg::addr_width-3:0]];

  logic [1:0]                     ar_stall = 2'd0;
  logic [1:0]                     aw_stall = 2'd0;
  logic [1:0]                     w_stall = 2'd0;
  logic                           r_full = 1'b0;
  logic                           b_full = 1'b0;
  logic                           aw_got = 1'b0;
  logic                           w_got = 1'b0;
  logic [mem_pkg::data_width-1:0] r_word = '0;
  logic [mem_pkg::addr_width-1:0] wr_addr = '0;
  logic [mem_pkg::data_width-1:0] wr_data = '0;
  logic [mem_pkg::strb_width-1:0] wr_strb = '0;
  int                             reads = 0;
  int                             writes = 0;

  function automatic logic [1:0] next_stall();
    int r;
    r = $random(seed);
    return r[1:0];
  endfunction

  // unwritten words read as a pattern of their address
  function automatic logic [31:0] read_word(logic [31:0] addr);
    if (mem.exists(addr[31:2])) return mem[addr[31:2]];
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] data,
                                             logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  assign arready     = (ar_stall == 2'd0) && !r_full;
  assign rvalid      = r_full;
  assign rdata       = r_word;
  assign rresp       = mem_pkg::resp_okay;
  assign rlast       = r_full;
  assign awready     = (aw_stall == 2'd0) && !aw_got && !b_full;
  assign wready      = (w_stall == 2'd0) && !w_got && !b_full;
  assign bvalid      = b_full;
  assign bresp       = mem_pkg::resp_okay;
  assign read_count  = reads;
  assign write_count = writes;

  always @(posedge clock) begin
    if (reset) begin
      r_full   <= 1'b0;
      b_full   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      reads    <= 0;
      writes   <= 0;
      ar_stall <= next_stall();
      aw_stall <= next_stall();
      w_stall  <= next_stall();
    end else begin
      if (arvalid && arready) begin
        r_full   <= 1'b1;
        r_word   <= read_word(araddr);
        reads    <= reads + 1;
        ar_stall <= next_stall();
      end else if (arvalid && ar_stall != 2'd0) begin
        ar_stall <= ar_stall - 2'd1;
      end
      if (r_full && rready) r_full <= 1'b0;
      if (awvalid && awready) begin
        aw_got   <= 1'b1;
        wr_addr  <= awaddr;
        writes   <= writes + 1;
        aw_stall <= next_stall();
      end else if (awvalid && aw_stall != 2'd0) begin
        aw_stall <= aw_stall - 2'd1;
      end
      if (wvalid && wready) begin
        // a beat without wlast leaves the burst open
        w_got   <= wlast;
        wr_data <= wdata;
        wr_strb <= wstrb;
        w_stall <= next_stall();
      end else if (wvalid && w_stall != 2'd0) begin
        w_stall <= w_stall - 2'd1;
      end
      // both halves in, commit and answer
      if (aw_got && w_got) begin
        mem[wr_addr[31:2]] = merge_word(read_word(wr_addr), wr_data, wr_strb);
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_full <= 1'b1;
      end
      if (b_full && bready) b_full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- sim/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

  localparam int wait_limit = 64;

  logic        clock;
  logic        reset;
  logic        fetch_valid, fetch_ready, fetch_resp_valid;
  logic [31:0] fetch_addr, fetch_resp_data;
  logic        lsu_valid, lsu_write, lsu_ready, lsu_resp_valid;
  logic [31:0] lsu_addr, lsu_wdata, lsu_resp_data;
  logic [3:0]  lsu_strb, wstrb;
  logic        arvalid, arready, rvalid, rlast, rready;
  logic        awvalid, awready, wvalid, wlast, wready, bvalid, bready;
  logic [31:0] araddr, rdata, awaddr, wdata;
  logic [1:0]  rresp, bresp;
  logic [31:0] read_count, write_count;

  int errors = 0;
  int timeouts = 0;

  mem_subsystem i_dut (.*);

  axi_mem_model i_mem (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic check_word(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic expect_latency(string what, int cycles, int expected);
    if (cycles != expected) begin
      errors++;
      $display("%s answered after %0d cycles instead of %0d", what, cycles, expected);
    end
  endtask

  // latency counts cycles from the accepting edge to the response
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data,
                            output int latency);
    int waited;
    data = '0;
    latency = 0;
    waited = 0;
    @(posedge clock);
    fetch_valid <= 1'b1;
    fetch_addr  <= addr;
    @(negedge clock);
    while (!fetch_ready && waited < wait_limit) begin
      waited++;
      @(negedge clock);
    end
    @(posedge clock);
    fetch_valid <= 1'b0;
    if (waited >= wait_limit) begin
      timeouts++;
      $display("fetch of %h was never accepted", addr);
      return;
    end
    do begin
      @(negedge clock);
      latency++;
    end while (!fetch_resp_valid && latency < wait_limit);
    if (!fetch_resp_valid) begin
      timeouts++;
      $display("no fetch response for %h", addr);
      return;
    end
    data = fetch_resp_data;
  endtask

  task automatic lsu_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata_in, input logic [3:0] strb,
                            output logic [31:0] data, output int latency);
    int waited;
    data = '0;
    latency = 0;
    waited = 0;
    @(posedge clock);
    lsu_valid <= 1'b1;
    lsu_write <= write;
    lsu_addr  <= addr;
    lsu_wdata <= wdata_in;
    lsu_strb  <= strb;
    @(negedge clock);
    while (!lsu_ready && waited < wait_limit) begin
      waited++;
      @(negedge clock);
    end
    @(posedge clock);
    lsu_valid <= 1'b0;
    if (waited >= wait_limit) begin
      timeouts++;
      $display("load/store to %h was never accepted", addr);
      return;
    end
    do begin
      @(negedge clock);
      latency++;
    end while (!lsu_resp_valid && latency < wait_limit);
    if (!lsu_resp_valid) begin
      timeouts++;
      $display("no load/store response for %h", addr);
      return;
    end
    data = lsu_resp_data;
  endtask

  task automatic miss_then_refill();
    logic [31:0] data;
    int          cycles;
    int          reads;
    reads = read_count;
    fetch_word(32'h0000_1040, data, cycles);
    check_word("fetch_resp_data", data, fill_word(32'h0000_1040));
    check_word("read_count", read_count, reads + 1);
  endtask

  task automatic hit_after_refill();
    logic [31:0] data;
    int          cycles;
    int          reads;
    reads = read_count;
    fetch_word(32'h0000_1040, data, cycles);
    check_word("fetch_resp_data", data, fill_word(32'h0000_1040));
    expect_latency("fetch hit", cycles, 1);
    check_word("read_count", read_count, reads);
  endtask

  // same index, other tag
  task automatic evict_and_refetch();
    logic [31:0] data;
    int          cycles;
    int          reads;
    reads = read_count;
    fetch_word(32'h0000_1080, data, cycles);
    check_word("fetch_resp_data", data, fill_word(32'h0000_1080));
    fetch_word(32'h0000_1040, data, cycles);
    check_word("fetch_resp_data", data, fill_word(32'h0000_1040));
    check_word("read_count", read_count, reads + 2);
  endtask

  task automatic store_then_load();
    logic [31:0] data;
    logic [31:0] merged;
    int          cycles;
    int          reads;
    int          writes;
    reads = read_count;
    writes = write_count;
    lsu_access(1'b1, 32'h0000_2008, 32'h1122_3344, 4'b0101, data, cycles);
    check_word("lsu_resp_data", data, 32'h0);
    check_word("write_count", write_count, writes + 1);
    check_word("read_count", read_count, reads);
    lsu_access(1'b0, 32'h0000_2008, 32'h0, 4'hf, data, cycles);
    // bytes 0 and 2 carry the store
    merged = (fill_word(32'h0000_2008) & 32'hff00_ff00) | (32'h1122_3344 & 32'h00ff_00ff);
    check_word("lsu_resp_data", data, merged);
    check_word("read_count", read_count, reads + 1);
  endtask

  task automatic read_timer();
    logic [31:0] hi_addr;
    logic [31:0] lo_addr;
    logic [31:0] data;
    logic [31:0] first;
    logic [31:0] second;
    int          cycles;
    int          reads;
    int          writes;
    hi_addr = {mem_pkg::clint_base[31:16], mem_pkg::clint_mtime_hi};
    lo_addr = {mem_pkg::clint_base[31:16], mem_pkg::clint_mtime_lo};
    reads = read_count;
    writes = write_count;
    lsu_access(1'b0, hi_addr, 32'h0, 4'hf, data, cycles);
    check_word("lsu_resp_data", data, 32'h0);
    expect_latency("timer high read", cycles, 1);
    lsu_access(1'b0, lo_addr, 32'h0, 4'hf, first, cycles);
    expect_latency("first timer low read", cycles, 1);
    lsu_access(1'b0, lo_addr, 32'h0, 4'hf, second, cycles);
    expect_latency("second timer low read", cycles, 1);
    if (second <= first) begin
      errors++;
      $display("ERROR lsu_resp_data: timer read %h not above earlier %h", second, first);
    end
    lsu_access(1'b1, lo_addr, 32'hffff_ffff, 4'hf, data, cycles);
    check_word("lsu_resp_data", data, 32'h0);
    expect_latency("timer write", cycles, 1);
    check_word("read_count", read_count, reads);
    check_word("write_count", write_count, writes);
  endtask

  // both requests in the same cycle, load/store goes first
  task automatic overlap_fetch_and_load();
    logic [31:0] fetch_data;
    logic [31:0] load_data;
    int          fetch_cycles;
    int          load_cycles;
    fork
      fetch_word(32'h0000_3000, fetch_data, fetch_cycles);
      lsu_access(1'b0, 32'h0000_4010, 32'h0, 4'hf, load_data, load_cycles);
    join
    check_word("fetch_resp_data", fetch_data, fill_word(32'h0000_3000));
    check_word("lsu_resp_data", load_data, fill_word(32'h0000_4010));
  endtask

  initial begin
    reset       = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    lsu_valid   = 1'b0;
    lsu_write   = 1'b0;
    lsu_addr    = '0;
    lsu_wdata   = '0;
    lsu_strb    = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    miss_then_refill();
    hit_after_refill();
    evict_and_refetch();
    store_then_load();
    read_timer();
    overlap_fetch_and_load();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
design/mem_pkg.sv
design/clint_timer.sv
design/icache.sv
design/mem_arbiter.sv
design/mem_subsystem.sv
sim/axi_mem_model.sv
sim/mem_subsystem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mem_subsystem_tb -f files.f -o mem_subsystem_sim || exit 1
output=$(./obj_dir/mem_subsystem_sim)
echo "$output"
echo "$output" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }
